// File: src/dist_cfg_pkg.sv
`default_nettype none

// sizing for the distribution chain and its data path
package dist_cfg_pkg;

    // widest chain that can be built
    // one mask bit per node, so this is also the mask width
    localparam int MAX_NODES = 8;

    localparam int DATA_WIDTH = 32;     // payload bits per word

    // per-node delivery counters, wrap at this width
    localparam int COUNT_WIDTH = 8;

    // all three must stay positive
    // NUM_NODES of any instance must not exceed MAX_NODES

endpackage

`default_nettype wire

// File: src/dist_flit_pkg.sv
`default_nettype none

// word formats moving through the chain and out to the nodes
package dist_flit_pkg;

    import dist_cfg_pkg::*;

    // destination mask, one hot per node
    // bit 0 is always the next node the word will reach
    typedef logic [MAX_NODES-1:0] dest_mask_t;

    // word on the chain between ingress and stages, 41 bits
    typedef struct packed {
        logic                  valid;   // one cycle per word
        dest_mask_t            mask;    // remaining destinations
        logic [DATA_WIDTH-1:0] data;    // payload
    } flit_t;

    // delivery into one node, 33 bits
    typedef struct packed {
        logic                  valid;   // delivery strobe
        logic [DATA_WIDTH-1:0] data;    // zero unless valid, at stage level
    } node_word_t;

endpackage

`default_nettype wire

// File: src/dist_ingress.sv
`default_nettype none

// request side of the chain
// checks the destination mask and turns a good request into a flit
// a bad one is thrown away here and flagged on o_drop
module dist_ingress #(
    parameter int NUM_NODES = 4                         // chain length, 1..MAX_NODES
) (
    input  wire logic                                   i_clk,
    input  wire logic                                   i_reset,
    input  wire logic                                   i_req_valid,    // single-cycle strobe
    input  wire dist_flit_pkg::dest_mask_t              i_req_mask,
    input  wire logic [dist_cfg_pkg::DATA_WIDTH-1:0]    i_req_data,
    output dist_flit_pkg::flit_t                        o_flit,
    output logic                                        o_drop
);

    import dist_cfg_pkg::*;
    import dist_flit_pkg::*;

    // bits that name real nodes, low NUM_NODES set
    localparam dest_mask_t LEGAL_MASK = {MAX_NODES{1'b1}} >> (MAX_NODES - NUM_NODES);

    logic mask_empty;       // nobody to deliver to
    logic mask_beyond;      // names a node past the end of the chain
    logic req_ok;

    assign mask_empty  = (i_req_mask == '0);
    assign mask_beyond = |(i_req_mask & ~LEGAL_MASK);
    assign req_ok      = !mask_empty && !mask_beyond;

    // one register stage, flit or drop shows at t+1
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_flit <= '0;
            o_drop <= 1'b0;
        end
        else
        begin
            o_drop       <= i_req_valid && !req_ok;     // rejected strobe
            o_flit.valid <= i_req_valid && req_ok;
            if (i_req_valid && req_ok)
            begin
                o_flit.mask <= i_req_mask;
                o_flit.data <= i_req_data;
            end
            else
            begin
                o_flit.mask <= '0;                      // idle flit stays all zero
                o_flit.data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dist_stage.sv
`default_nettype none

// registered 1-to-2 distribute switch
// mask bit 0 decides whether this stage's node takes a copy
// the word always goes on, mask shifted down by one
module dist_stage (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire dist_flit_pkg::flit_t   i_flit,     // from ingress or previous stage
    output dist_flit_pkg::flit_t        o_flit,     // to next stage
    output dist_flit_pkg::node_word_t   o_node      // to this stage's node
);

    logic take;     // this node is named

    assign take = i_flit.valid && i_flit.mask[0];

    // pass-through half
    // every valid word moves on, even with an empty remaining mask
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_flit <= '0;
        end
        else if (i_flit.valid)
        begin
            o_flit.valid <= 1'b1;
            o_flit.mask  <= i_flit.mask >> 1;   // zero enters at top
            o_flit.data  <= i_flit.data;
        end
        else
        begin
            o_flit <= '0;                       // no word, everything low
        end
    end

    // node half
    // data is forced to zero whenever there is no delivery
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_node <= '0;
        end
        else if (take)
        begin
            o_node.valid <= 1'b1;
            o_node.data  <= i_flit.data;
        end
        else
        begin
            o_node.valid <= 1'b0;
            o_node.data  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/dist_chain.sv
`default_nettype none

// NUM_NODES distribution stages in a row
// stage k feeds stage k+1, each node word lands in slot k
module dist_chain #(
    parameter int NUM_NODES = 4                                 // number of stages
) (
    input  wire logic                                           i_clk,
    input  wire logic                                           i_reset,
    input  wire dist_flit_pkg::flit_t                           i_flit,     // from ingress
    output dist_flit_pkg::node_word_t [NUM_NODES-1:0]           o_node
);

    import dist_flit_pkg::*;

    // link[k] is the flit entering stage k
    flit_t [NUM_NODES-1:0] link;

    assign link[0] = i_flit;

    for (genvar k = 0; k < NUM_NODES; k++)
    begin : g_stage
        if (k == NUM_NODES - 1)
        begin : g_last
            // end of the line, the passed word is discarded
            dist_stage i_stage (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_flit  (link[k]),
                .o_flit  (),
                .o_node  (o_node[k])
            );
        end
        else
        begin : g_mid
            dist_stage i_stage (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_flit  (link[k]),
                .o_flit  (link[k+1]),       // on to the next stage
                .o_node  (o_node[k])
            );
        end
    end

endmodule

`default_nettype wire

// File: src/dist_egress.sv
`default_nettype none

// node side of the chain
// keeps the last word each node received and counts the deliveries
module dist_egress #(
    parameter int NUM_NODES = 4                                         // node count
) (
    input  wire logic                                                   i_clk,
    input  wire logic                                                   i_reset,
    input  wire dist_flit_pkg::node_word_t [NUM_NODES-1:0]              i_node,
    output dist_flit_pkg::node_word_t [NUM_NODES-1:0]                   o_node,
    output logic [NUM_NODES-1:0][dist_cfg_pkg::COUNT_WIDTH-1:0]         o_count
);

    import dist_cfg_pkg::*;

    // counter step, sized to the counter so the add wraps cleanly
    localparam logic [COUNT_WIDTH-1:0] COUNT_ONE = COUNT_WIDTH'(1);

    // delivery strobe, one cycle behind the stage
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_node <= '0;
        end
        else
        begin
            for (int k = 0; k < NUM_NODES; k++)
            begin
                o_node[k].valid <= i_node[k].valid;
                if (i_node[k].valid)
                begin
                    o_node[k].data <= i_node[k].data;   // held until the next delivery
                end
            end
        end
    end

    // per-node delivery counters
    // bumped together with the registered strobe, so they agree at t+3+k
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_count <= '0;
        end
        else
        begin
            for (int k = 0; k < NUM_NODES; k++)
            begin
                if (i_node[k].valid)
                begin
                    o_count[k] <= o_count[k] + COUNT_ONE;   // wraps at width
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dist_top.sv
`default_nettype none

// multicast distribution chain
// request in, one registered stage per node, delivery registers out
// latency to node k is 3+k cycles, a drop shows after 1
module dist_top #(
    parameter int NUM_NODES = 4                                         // 1..MAX_NODES
) (
    input  wire logic                                                   i_clk,
    input  wire logic                                                   i_reset,

    // request, strobe only, never stalled
    input  wire logic                                                   i_req_valid,
    input  wire dist_flit_pkg::dest_mask_t                              i_req_mask,
    input  wire logic [dist_cfg_pkg::DATA_WIDTH-1:0]                    i_req_data,

    // results
    output logic                                                        o_drop,
    output dist_flit_pkg::node_word_t [NUM_NODES-1:0]                   o_node,
    output logic [NUM_NODES-1:0][dist_cfg_pkg::COUNT_WIDTH-1:0]         o_count
);

    import dist_flit_pkg::*;

    flit_t                       in_flit;      // ingress to first stage
    node_word_t [NUM_NODES-1:0]  stage_node;   // raw stage deliveries

    // mask check and input register
    dist_ingress #(
        .NUM_NODES (NUM_NODES)
    ) i_ingress (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .i_req_mask  (i_req_mask),
        .i_req_data  (i_req_data),
        .o_flit      (in_flit),
        .o_drop      (o_drop)
    );

    // the stages themselves
    dist_chain #(
        .NUM_NODES (NUM_NODES)
    ) i_chain (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flit  (in_flit),
        .o_node  (stage_node)
    );

    // hold and count per node
    dist_egress #(
        .NUM_NODES (NUM_NODES)
    ) i_egress (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_node  (stage_node),
        .o_node  (o_node),
        .o_count (o_count)
    );

endmodule

`default_nettype wire

// File: include/dist_tb_vectors.svh
`ifndef DIST_TB_VECTORS_SVH
`define DIST_TB_VECTORS_SVH

// directed requests, one row each
// columns are mask, data, exp_drop, gap
// gap counts idle cycles after the strobe, 0 means the next row follows back to back
// exp_drop is for a chain of 4 nodes
typedef struct packed {
    dist_flit_pkg::dest_mask_t mask;    // requested destinations
    logic [31:0]               data;
    logic                      exp_drop;    // ingress must reject it
    logic [3:0]                gap;
} vec_t;

localparam int NUM_VECTORS = 24;

localparam vec_t VECTORS [NUM_VECTORS] = '{
    // unicast, one node at a time, well spaced
    '{8'h01, 32'h1111_0001, 1'b0, 4'd8},
    '{8'h02, 32'h2222_0002, 1'b0, 4'd8},
    '{8'h04, 32'h4444_0004, 1'b0, 4'd8},
    '{8'h08, 32'h8888_0008, 1'b0, 4'd8},
    // multicast patterns
    '{8'h03, 32'hcafe_0003, 1'b0, 4'd7},
    '{8'h05, 32'hbeef_0005, 1'b0, 4'd6},
    '{8'h0a, 32'h0ddb_a11a, 1'b0, 4'd8},
    '{8'h0f, 32'hffff_000f, 1'b0, 4'd8},
    '{8'h0e, 32'h1234_5678, 1'b0, 4'd7},
    '{8'h09, 32'h8765_4321, 1'b0, 4'd8},
    // empty mask and masks past the end of the chain
    '{8'h00, 32'hdead_0000, 1'b1, 4'd3},
    '{8'h10, 32'hdead_0010, 1'b1, 4'd3},
    '{8'h80, 32'hdead_0080, 1'b1, 4'd3},
    '{8'h1f, 32'hdead_001f, 1'b1, 4'd3},
    '{8'hf0, 32'hdead_00f0, 1'b1, 4'd3},
    // back to back burst, drop in the middle
    '{8'h01, 32'ha000_0001, 1'b0, 4'd0},
    '{8'h02, 32'ha000_0002, 1'b0, 4'd0},
    '{8'h04, 32'ha000_0004, 1'b0, 4'd0},
    '{8'h08, 32'ha000_0008, 1'b0, 4'd0},
    '{8'h0f, 32'ha000_000f, 1'b0, 4'd0},
    '{8'h06, 32'ha000_0006, 1'b0, 4'd0},
    '{8'h20, 32'ha000_0020, 1'b1, 4'd0},
    '{8'h0b, 32'ha000_000b, 1'b0, 4'd0},
    '{8'h0c, 32'ha000_000c, 1'b0, 4'd6}
};

`endif

// File: test/dist_top_tb.sv
`default_nettype none

module dist_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dist_cfg_pkg::*;
    import dist_flit_pkg::*;

    localparam int NUM_NODES = 4;
    localparam int COUNT_MOD = 1 << COUNT_WIDTH;    // counters wrap here

    `include "dist_tb_vectors.svh"

    // one expected drop or delivery, due in cycle "due"
    typedef struct packed {
        int                    due;
        logic                  is_drop;
        logic [2:0]            node;
        logic [DATA_WIDTH-1:0] data;
    } event_t;

    logic                                       i_clk = 1'b0;
    logic                                       i_reset;
    logic                                       i_req_valid;
    dest_mask_t                                 i_req_mask;
    logic [DATA_WIDTH-1:0]                      i_req_data;
    logic                                       o_drop;
    node_word_t [NUM_NODES-1:0]                 o_node;
    logic [NUM_NODES-1:0][COUNT_WIDTH-1:0]      o_count;

    int          cyc = 0;           // edges seen so far
    logic        checking = 1'b0;   // per-cycle compare on
    event_t      pending [$];       // scoreboard queue
    logic [31:0] model_data [NUM_NODES];
    int          model_count [NUM_NODES];
    logic [31:0] rnd_state = 32'hdc90_21e2;

    dist_top #(
        .NUM_NODES (NUM_NODES)
    ) i_dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .i_req_mask  (i_req_mask),
        .i_req_data  (i_req_data),
        .o_drop      (o_drop),
        .o_node      (o_node),
        .o_count     (o_count)
    );

    always #20 i_clk = ~i_clk;      // 40 ns period

    always @(posedge i_clk)
    begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // strobe one request and book its drop or its deliveries
    task automatic drive_request(input dest_mask_t mask, input logic [31:0] data,
                                 input logic drop);
        event_t ev;
        @(posedge i_clk);
        #2;
        i_req_valid = 1'b1;
        i_req_mask  = mask;
        i_req_data  = data;
        ev.data = data;
        if (drop)
        begin
            ev.due     = cyc + 1;       // drop one cycle on
            ev.is_drop = 1'b1;
            ev.node    = '0;
            pending.push_back(ev);
        end
        else
        begin
            for (int k = 0; k < NUM_NODES; k++)
            begin
                if (mask[k])
                begin
                    ev.due     = cyc + 3 + k;   // one more cycle per stage
                    ev.is_drop = 1'b0;
                    ev.node    = 3'(k);
                    pending.push_back(ev);
                end
            end
        end
    endtask

    task automatic drive_idle();
        @(posedge i_clk);
        #2;
        i_req_valid = 1'b0;
        i_req_mask  = '0;
        i_req_data  = '0;
    endtask

    // retire everything due now, then compare all outputs
    task automatic check_outputs();
        logic [NUM_NODES-1:0] exp_valid;
        logic                 exp_drop;
        int                   i;
        exp_valid = '0;
        exp_drop  = 1'b0;
        i = 0;
        while (i < pending.size())
        begin
            if (pending[i].due == cyc)
            begin
                if (pending[i].is_drop)
                begin
                    exp_drop = 1'b1;
                end
                else
                begin
                    exp_valid[pending[i].node]   = 1'b1;
                    model_data[pending[i].node]  = pending[i].data;   // held by egress
                    model_count[pending[i].node] = model_count[pending[i].node] + 1;
                end
                pending.delete(i);
            end
            else
            begin
                i++;
            end
        end
        compare_value(o_drop, exp_drop, "drop strobe");
        for (int k = 0; k < NUM_NODES; k++)
        begin
            compare_value(o_node[k].valid, exp_valid[k], $sformatf("node %0d valid", k));
            compare_value(o_node[k].data, model_data[k], $sformatf("node %0d data", k));
            compare_value(o_count[k], model_count[k] % COUNT_MOD,
                          $sformatf("node %0d count", k));
        end
    endtask

    always @(negedge i_clk)     // outputs settled mid cycle
    begin
        if (checking)
        begin
            check_outputs();
        end
    end

    task automatic wait_for_drain(input int max_cycles);
        int n;
        n = 0;
        while (pending.size() != 0)
        begin
            if (n >= max_cycles)
            begin
                $display("timeout: %0d expected outputs still missing after %0d cycles",
                         pending.size(), max_cycles);
                abort_run();
            end
            else
            begin
                @(posedge i_clk);
                n++;
            end
        end
        repeat (2) @(posedge i_clk);    // let the last compare run
    endtask

    initial
    begin
        dest_mask_t  mask;
        logic [31:0] data;
        logic        drop;
        int          gap;
        i_reset     = 1'b1;
        i_req_valid = 1'b0;
        i_req_mask  = '0;
        i_req_data  = '0;
        for (int k = 0; k < NUM_NODES; k++)
        begin
            model_data[k]  = '0;
            model_count[k] = 0;
        end
        repeat (10) @(posedge i_clk);
        #2;
        i_reset  = 1'b0;
        checking = 1'b1;

        // reset state, nothing requested yet
        @(negedge i_clk);
        compare_value(o_drop, 1'b0, "drop after reset");
        for (int k = 0; k < NUM_NODES; k++)
        begin
            compare_value(o_node[k].valid, 1'b0, $sformatf("node %0d valid after reset", k));
            compare_value(o_count[k], 0, $sformatf("node %0d count after reset", k));
        end

        // directed table
        for (int v = 0; v < NUM_VECTORS; v++)
        begin
            drive_request(VECTORS[v].mask, VECTORS[v].data, VECTORS[v].exp_drop);
            repeat (VECTORS[v].gap) drive_idle();
        end
        drive_idle();
        wait_for_drain(20);

        // random phase, mostly legal masks, some out of range
        for (int n = 0; n < 300; n++)
        begin
            rnd_state = xorshift32(rnd_state);
            if (rnd_state[31:30] != 2'b00)
                mask = {4'b0000, rnd_state[3:0]};
            else
                mask = rnd_state[11:4];
            gap = int'(rnd_state[17:16]);   // 0 is back to back
            rnd_state = xorshift32(rnd_state);
            data = rnd_state;
            drop = (mask == '0) || ((mask >> NUM_NODES) != '0);
            drive_request(mask, data, drop);
            repeat (gap) drive_idle();
        end
        drive_idle();
        wait_for_drain(20);

        for (int k = 0; k < NUM_NODES; k++)
        begin
            compare_value(o_count[k], model_count[k] % COUNT_MOD,
                          $sformatf("node %0d final count", k));
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
src/dist_cfg_pkg.sv
src/dist_flit_pkg.sv
src/dist_ingress.sv
src/dist_stage.sv
src/dist_chain.sv
src/dist_egress.sv
src/dist_top.sv
test/dist_top_tb.sv
